//--- spi_map_pkg.sv
// ----------------------------------------------------------
// SPI fan-out map definitions
// Bank numbering, per-bank line widths, idle pin levels and
// the shift engine state encoding
// ----------------------------------------------------------

package spi_map_pkg;

    localparam int NUM_BANKS = 4;           // PA, two TX DSA groups, ORX
    localparam int BANK_W    = 2;           // Bank select field width
    localparam int LE_WIDTH  = 8;           // Latch enables per bank

    // Idle levels, everything parks high
    localparam logic                SCLK_IDLE = 1'b1;   // Mode 3 clock idles high
    localparam logic                MOSI_IDLE = 1'b1;
    localparam logic [LE_WIDTH-1:0] LE_IDLE   = {LE_WIDTH{1'b1}};

    typedef enum logic [BANK_W-1:0] {
        bank_pa      = 2'd0,                // Power amplifier board
        bank_tx_low  = 2'd1,                // TX attenuators 1..4
        bank_tx_high = 2'd2,                // TX attenuators 5..8, write only
        bank_orx     = 2'd3                 // Observation receiver
    } bank_e;

    typedef enum logic [1:0] {st_idle, st_setup, st_shift, st_hold} eng_state_e;

endpackage

//--- spi_reg_pkg.sv
// ----------------------------------------------------------
// SPI fan-out register map
// APB offsets and control/status field layout
// ----------------------------------------------------------

package spi_reg_pkg;

    localparam int APB_ADDR_W = 4;          // 16 byte register window
    localparam int APB_DATA_W = 32;

    localparam int DATA_W   = 8;            // One byte per transfer
    localparam int CS_IDX_W = 3;            // Selects one of eight LE lines

    // Control register fields
    localparam int CTRL_BANK_LSB = 0;       // Bank select at [1:0]
    localparam int CTRL_CS_LSB   = 4;       // Chip-select index at [6:4]

    // Status register fields
    localparam int STAT_BUSY_BIT = 0;

    typedef enum logic [APB_ADDR_W-1:0] {
        reg_ctrl   = 4'h0,                  // Bank and chip-select index
        reg_tx     = 4'h4,                  // Write starts a transfer
        reg_rx     = 4'h8,                  // Last received byte
        reg_status = 4'hC                   // Busy flag
    } reg_addr_e;

endpackage

//--- spi_bus_if.sv
// ----------------------------------------------------------
// SPI bus bundle
// Clock, data out, active low selects and data in
// ----------------------------------------------------------

interface spi_bus_if;

    logic                             sclk;
    logic                             mosi;
    logic [spi_map_pkg::LE_WIDTH-1:0] ss_n;     // One line per device, active low
    logic                             miso;

    // Drives the lines, gets the reply
    modport master (output sclk, output mosi, output ss_n, input miso);

    // Receives the lines, returns the reply
    modport slave (input sclk, input mosi, input ss_n, output miso);

endinterface

//--- spi_apb_regs.sv
// ----------------------------------------------------------
// SPI fan-out APB register block
// Control, transmit, receive and status registers, zero
// wait state, error response on bad address or on a
// transmit write while a transfer is running
// ----------------------------------------------------------

module spi_apb_regs (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [spi_reg_pkg::APB_ADDR_W-1:0]   paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [spi_reg_pkg::APB_DATA_W-1:0]   pwdata,
    output logic [spi_reg_pkg::APB_DATA_W-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output spi_map_pkg::bank_e                   bank_sel,
    output logic [spi_reg_pkg::CS_IDX_W-1:0]     cs_idx,
    output logic [spi_reg_pkg::DATA_W-1:0]       tx_data,
    output logic                                 start,
    input  logic [spi_reg_pkg::DATA_W-1:0]       rx_data,
    input  logic                                 done
);

    spi_reg_pkg::reg_addr_e          addr;
    logic                            access;        // APB access phase
    logic                            addr_ok;
    logic                            ctrl_wr;
    logic                            tx_wr;         // Accepted transmit write
    logic                            busy;
    logic [spi_reg_pkg::DATA_W-1:0]  rx_q;

    assign addr   = spi_reg_pkg::reg_addr_e'(paddr);
    assign access = psel & penable;
    assign pready = 1'b1;                           // Never stalls

    always_comb begin
        case (addr)
            spi_reg_pkg::reg_ctrl,
            spi_reg_pkg::reg_tx,
            spi_reg_pkg::reg_rx,
            spi_reg_pkg::reg_status: addr_ok = 1'b1;
            default:                 addr_ok = 1'b0;
        endcase
    end

    assign ctrl_wr = access & pwrite & (addr == spi_reg_pkg::reg_ctrl);
    assign tx_wr   = access & pwrite & (addr == spi_reg_pkg::reg_tx) & ~busy;
    assign pslverr = access & (~addr_ok | (pwrite & (addr == spi_reg_pkg::reg_tx) & busy));

    // Control register and transfer tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank_sel <= spi_map_pkg::bank_pa;
            cs_idx   <= '0;
            start    <= 1'b0;
            busy     <= 1'b0;
        end else begin
            start <= tx_wr;                         // Engine sees it next cycle
            if (ctrl_wr) begin
                bank_sel <= spi_map_pkg::bank_e'(pwdata[spi_reg_pkg::CTRL_BANK_LSB +:
                                                        spi_map_pkg::BANK_W]);
                cs_idx   <= pwdata[spi_reg_pkg::CTRL_CS_LSB +: spi_reg_pkg::CS_IDX_W];
            end
            if (tx_wr)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;                       // Clears with the rx update
        end
    end

    // Payload bytes
    always_ff @(posedge clk) begin
        if (tx_wr)
            tx_data <= pwdata[spi_reg_pkg::DATA_W-1:0];
        if (done)
            rx_q <= rx_data;
    end

    // Read mux
    always_comb begin
        prdata = '0;
        case (addr)
            spi_reg_pkg::reg_ctrl: begin
                prdata[spi_reg_pkg::CTRL_BANK_LSB +: spi_map_pkg::BANK_W] = bank_sel;
                prdata[spi_reg_pkg::CTRL_CS_LSB +: spi_reg_pkg::CS_IDX_W]  = cs_idx;
            end
            spi_reg_pkg::reg_tx:     prdata[spi_reg_pkg::DATA_W-1:0] = tx_data;
            spi_reg_pkg::reg_rx:     prdata[spi_reg_pkg::DATA_W-1:0] = rx_q;
            spi_reg_pkg::reg_status: prdata[spi_reg_pkg::STAT_BUSY_BIT] = busy;
            default:                 prdata = '0;
        endcase
    end

endmodule

//--- spi_shift_engine.sv
// ----------------------------------------------------------
// SPI mode 3 byte shift engine
// Divided SCLK, one-hot active low select, MSB first out on
// falling edges, one shared shift register for in and out
// ----------------------------------------------------------

module spi_shift_engine #(
    parameter int CLK_DIV = 4                       // Sys cycles per SCLK half period
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              start,
    input  logic [spi_reg_pkg::CS_IDX_W-1:0]  cs_idx,
    input  logic [spi_reg_pkg::DATA_W-1:0]    tx_data,
    output logic                              done,
    output logic [spi_reg_pkg::DATA_W-1:0]    rx_data,
    spi_bus_if.master                         bus
);

    localparam int DIV_W     = $clog2(CLK_DIV + 1);
    localparam int HALFS     = 2 * spi_reg_pkg::DATA_W;    // Half periods per byte
    localparam int HALF_W    = $clog2(HALFS);

    spi_map_pkg::eng_state_e             state;
    logic [DIV_W-1:0]                    div_cnt;
    logic                                div_last;
    logic [HALF_W-1:0]                   half_cnt;       // Bit counter in half periods
    logic [spi_reg_pkg::DATA_W-1:0]      shreg;          // Out at MSB, in at LSB
    logic                                sclk_q;
    logic                                mosi_q;
    logic [spi_map_pkg::LE_WIDTH-1:0]    ss_n_q;

    assign div_last = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= spi_map_pkg::st_idle;
            div_cnt  <= '0;
            half_cnt <= '0;
            sclk_q   <= spi_map_pkg::SCLK_IDLE;
            mosi_q   <= spi_map_pkg::MOSI_IDLE;
            ss_n_q   <= spi_map_pkg::LE_IDLE;
        end else begin
            div_cnt <= div_last ? '0 : div_cnt + 1'b1;
            case (state)
                spi_map_pkg::st_idle: begin
                    div_cnt <= '0;                          // Phase starts clean
                    if (start) begin
                        state  <= spi_map_pkg::st_setup;
                        ss_n_q <= ~(spi_map_pkg::LE_WIDTH'(1) << cs_idx);
                    end
                end
                spi_map_pkg::st_setup: begin                // CS low, SCLK still high
                    if (div_last) begin
                        state    <= spi_map_pkg::st_shift;
                        half_cnt <= '0;
                        sclk_q   <= 1'b0;                   // First falling edge
                        mosi_q   <= shreg[spi_reg_pkg::DATA_W-1];
                    end
                end
                spi_map_pkg::st_shift: begin
                    if (div_last) begin
                        half_cnt <= half_cnt + 1'b1;
                        if (!sclk_q) begin
                            sclk_q <= 1'b1;                 // Rising edge
                        end else if (half_cnt == HALF_W'(HALFS - 1)) begin
                            state <= spi_map_pkg::st_hold;  // Last bit, SCLK stays high
                        end else begin
                            sclk_q <= 1'b0;
                            mosi_q <= shreg[spi_reg_pkg::DATA_W-2];
                        end
                    end
                end
                spi_map_pkg::st_hold: begin
                    if (div_last) begin
                        state  <= spi_map_pkg::st_idle;
                        ss_n_q <= spi_map_pkg::LE_IDLE;     // Deselect with done
                        mosi_q <= spi_map_pkg::MOSI_IDLE;
                    end
                end
                default: state <= spi_map_pkg::st_idle;
            endcase
        end
    end

    // Payload shifter, load on start, sample at end of each high phase
    // so the bank port delay on SCLK is covered
    always_ff @(posedge clk) begin
        if (state == spi_map_pkg::st_idle && start)
            shreg <= tx_data;
        else if (state == spi_map_pkg::st_shift && div_last && sclk_q)
            shreg <= {shreg[spi_reg_pkg::DATA_W-2:0], bus.miso};
    end

    assign done    = (state == spi_map_pkg::st_hold) && div_last;
    assign rx_data = shreg;                         // Full rx byte during hold

    assign bus.sclk = sclk_q;
    assign bus.mosi = mosi_q;
    assign bus.ss_n = ss_n_q;

endmodule

//--- spi_bank_router.sv
// ----------------------------------------------------------
// SPI bank router
// Steers the engine bus to the selected bank, parks other
// banks high and muxes back the selected MISO
// ----------------------------------------------------------

module spi_bank_router #(
    parameter logic [spi_map_pkg::NUM_BANKS-1:0] MISO_MASK = '0   // Set bit, MISO not wired
) (
    input  spi_map_pkg::bank_e  bank_sel,
    spi_bus_if.slave            eng,
    spi_bus_if.master           banks [spi_map_pkg::NUM_BANKS]
);

    logic [spi_map_pkg::NUM_BANKS-1:0] miso_vec;    // Per bank, after masking

    for (genvar b = 0; b < spi_map_pkg::NUM_BANKS; b++) begin : g_bank
        logic hit;

        assign hit = (bank_sel == spi_map_pkg::bank_e'(b));

        assign banks[b].sclk = hit ? eng.sclk : spi_map_pkg::SCLK_IDLE;
        assign banks[b].mosi = hit ? eng.mosi : spi_map_pkg::MOSI_IDLE;
        assign banks[b].ss_n = hit ? eng.ss_n : spi_map_pkg::LE_IDLE;

        // Write-only banks read back as ones
        assign miso_vec[b] = MISO_MASK[b] ? 1'b1 : banks[b].miso;
    end

    assign eng.miso = miso_vec[bank_sel];

endmodule

//--- spi_bank_port.sv
// ----------------------------------------------------------
// SPI bank port
// Registered pin stage for one bank, parks high when the
// bank is not selected, MISO passes straight up
// ----------------------------------------------------------

module spi_bank_port #(
    parameter int BANK_ID = 0
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  spi_map_pkg::bank_e                bank_sel,
    spi_bus_if.slave                          up,
    output logic                              pin_sclk,
    output logic                              pin_mosi,
    output logic [spi_map_pkg::LE_WIDTH-1:0]  pin_le,
    input  logic                              pin_miso
);

    logic active;

    assign active = (bank_sel == spi_map_pkg::bank_e'(BANK_ID));

    // One clock of delay, flops keep the pins clean on bank switches
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pin_sclk <= spi_map_pkg::SCLK_IDLE;
            pin_mosi <= spi_map_pkg::MOSI_IDLE;
            pin_le   <= spi_map_pkg::LE_IDLE;
        end else begin
            pin_sclk <= active ? up.sclk : spi_map_pkg::SCLK_IDLE;
            pin_mosi <= active ? up.mosi : spi_map_pkg::MOSI_IDLE;
            pin_le   <= active ? up.ss_n : spi_map_pkg::LE_IDLE;
        end
    end

    assign up.miso = pin_miso;                      // No delay on the way back

endmodule

//--- spi_map_top.sv
// ----------------------------------------------------------
// SPI fan-out subsystem top
// APB registers, shift engine, bank router and one
// registered pin port per device bank
// ----------------------------------------------------------

module spi_map_top #(
    parameter int                                CLK_DIV   = 4,
    parameter logic [spi_map_pkg::NUM_BANKS-1:0] MISO_MASK =
        spi_map_pkg::NUM_BANKS'(1) << spi_map_pkg::bank_tx_high    // TX high group is write only
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [spi_reg_pkg::APB_ADDR_W-1:0]    paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [spi_reg_pkg::APB_DATA_W-1:0]    pwdata,
    output logic [spi_reg_pkg::APB_DATA_W-1:0]    prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic [spi_map_pkg::NUM_BANKS-1:0]     bank_sclk,
    output logic [spi_map_pkg::NUM_BANKS-1:0]     bank_mosi,
    output logic [spi_map_pkg::NUM_BANKS-1:0][spi_map_pkg::LE_WIDTH-1:0] bank_le,
    input  logic [spi_map_pkg::NUM_BANKS-1:0]     bank_miso
);

    spi_map_pkg::bank_e                bank_sel;
    logic [spi_reg_pkg::CS_IDX_W-1:0]  cs_idx;
    logic [spi_reg_pkg::DATA_W-1:0]    tx_data;
    logic [spi_reg_pkg::DATA_W-1:0]    rx_data;
    logic                              start;
    logic                              done;

    spi_bus_if eng_bus ();                          // Engine to router
    spi_bus_if bank_bus [spi_map_pkg::NUM_BANKS] ();   // Router to each port

    spi_apb_regs u_regs (
        .clk      (clk),      .arst_n  (arst_n),
        .paddr    (paddr),    .psel    (psel),
        .penable  (penable),  .pwrite  (pwrite),
        .pwdata   (pwdata),   .prdata  (prdata),
        .pready   (pready),   .pslverr (pslverr),
        .bank_sel (bank_sel), .cs_idx  (cs_idx),
        .tx_data  (tx_data),  .start   (start),
        .rx_data  (rx_data),  .done    (done)
    );

    spi_shift_engine #(.CLK_DIV(CLK_DIV)) u_engine (
        .clk     (clk),     .arst_n  (arst_n),
        .start   (start),   .cs_idx  (cs_idx),
        .tx_data (tx_data), .done    (done),
        .rx_data (rx_data), .bus     (eng_bus)
    );

    spi_bank_router #(.MISO_MASK(MISO_MASK)) u_router (
        .bank_sel (bank_sel),
        .eng      (eng_bus),
        .banks    (bank_bus)
    );

    for (genvar b = 0; b < spi_map_pkg::NUM_BANKS; b++) begin : g_port
        spi_bank_port #(.BANK_ID(b)) u_port (
            .clk      (clk),          .arst_n   (arst_n),
            .bank_sel (bank_sel),     .up       (bank_bus[b]),
            .pin_sclk (bank_sclk[b]), .pin_mosi (bank_mosi[b]),
            .pin_le   (bank_le[b]),   .pin_miso (bank_miso[b])
        );
    end

endmodule

//--- tb_spi_slave.sv
// ----------------------------------------------------------
// SPI slave model for one device bank
// Mode 3, captures MOSI on rising SCLK while any LE is low
// and returns a reply byte MSB first on falling SCLK
// ----------------------------------------------------------

module tb_spi_slave (
    input  logic                              sclk,
    input  logic                              mosi,
    input  logic [spi_map_pkg::LE_WIDTH-1:0]  le,
    input  logic [spi_reg_pkg::DATA_W-1:0]    reply,
    output logic                              miso,
    output logic [spi_reg_pkg::DATA_W-1:0]    rx_byte,
    output logic [3:0]                        rx_bits
);

    timeunit 1ns;
    timeprecision 1ps;

    logic                           sel;
    logic                           sel_q;
    logic                           sclk_q;
    logic [spi_reg_pkg::DATA_W-1:0] tx_sh;      // Reply bits still to send

    assign sel = ~&le;                          // Any latch enable low

    initial begin
        miso    = 1'b1;
        rx_byte = '0;
        rx_bits = '0;
        tx_sh   = '1;
        sel_q   = 1'b0;
        sclk_q  = 1'b1;
        forever begin
            @(sclk or sel);
            if (sel && !sel_q) begin            // New frame
                rx_byte = '0;
                rx_bits = '0;
                tx_sh   = reply;
            end
            if (sel && sclk && !sclk_q) begin
                rx_byte = {rx_byte[spi_reg_pkg::DATA_W-2:0], mosi};
                rx_bits = rx_bits + 4'd1;
            end
            if (sel && !sclk && sclk_q) begin   // Next reply bit
                miso  = tx_sh[spi_reg_pkg::DATA_W-1];
                tx_sh = {tx_sh[spi_reg_pkg::DATA_W-2:0], 1'b1};
            end
            sclk_q = sclk;
            sel_q  = sel;
        end
    end

endmodule

//--- tb_spi_map.sv
// ----------------------------------------------------------
// SPI fan-out testbench
// Table of transfers over all banks through APB, one slave
// model per bank and a pin monitor on the idle banks
// ----------------------------------------------------------

module tb_spi_map;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB       = spi_map_pkg::NUM_BANKS;
    localparam int LEW      = spi_map_pkg::LE_WIDTH;
    localparam int DW       = spi_reg_pkg::DATA_W;
    localparam int AW       = spi_reg_pkg::APB_ADDR_W;
    localparam int PW       = spi_reg_pkg::APB_DATA_W;
    localparam int ROWS     = 7;
    localparam int POKE_ROW = 3;                // Gets a second tx write while busy
    localparam int POLL_MAX = 40;               // Status reads per transfer
    localparam int APB_MAX  = 16;
    localparam spi_map_pkg::bank_e MASKED_BANK = spi_map_pkg::bank_tx_high;

    typedef struct packed {
        spi_map_pkg::bank_e               bank;
        logic [spi_reg_pkg::CS_IDX_W-1:0] cs;
        logic [DW-1:0]                    tx;
        logic [DW-1:0]                    reply;
    } row_t;

    logic                    clk;
    logic                    arst_n;
    logic [AW-1:0]           paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [PW-1:0]           pwdata;
    logic [PW-1:0]           prdata;
    logic                    pready;
    logic                    pslverr;
    logic [NB-1:0]           bank_sclk;
    logic [NB-1:0]           bank_mosi;
    logic [NB-1:0][LEW-1:0]  bank_le;
    wire  [NB-1:0]           bank_miso;
    wire  [NB-1:0][DW-1:0]   slv_rx;            // Bytes seen by each slave
    wire  [NB-1:0][3:0]      slv_bits;
    logic [NB-1:0][DW-1:0]   reply;

    row_t                             rows [ROWS];
    int                               seed;
    int                               checks;
    int                               errors;
    int                               timeouts;
    logic                             mon_on;
    logic                             le_seen;
    spi_map_pkg::bank_e               mon_bank;
    logic [spi_reg_pkg::CS_IDX_W-1:0] mon_cs;

    spi_map_top #(.CLK_DIV(2)) u_spi_map_top (
        .clk       (clk),       .arst_n    (arst_n),
        .paddr     (paddr),     .psel      (psel),
        .penable   (penable),   .pwrite    (pwrite),
        .pwdata    (pwdata),    .prdata    (prdata),
        .pready    (pready),    .pslverr   (pslverr),
        .bank_sclk (bank_sclk), .bank_mosi (bank_mosi),
        .bank_le   (bank_le),   .bank_miso (bank_miso)
    );

    for (genvar b = 0; b < NB; b++) begin : g_slave
        tb_spi_slave u_slave (
            .sclk    (bank_sclk[b]), .mosi    (bank_mosi[b]),
            .le      (bank_le[b]),   .reply   (reply[b]),
            .miso    (bank_miso[b]), .rx_byte (slv_rx[b]),
            .rx_bits (slv_bits[b])
        );
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [DW-1:0] rand_byte();
        rand_byte = DW'($random(seed));
    endfunction

    // Expected latch enables with only line idx low
    function automatic logic [LEW-1:0] le_pattern(
        input logic [spi_reg_pkg::CS_IDX_W-1:0] idx);
        logic [LEW-1:0] v;
        for (int i = 0; i < LEW; i++) begin
            v[i] = (i != int'(idx));
        end
        return v;
    endfunction

    task automatic check_byte(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_pins(input string name, input logic [LEW-1:0] got,
                              input logic [LEW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // One APB transfer with setup and access phase
    task automatic apb_access(input logic [AW-1:0] addr, input logic write,
                              input logic [PW-1:0] wdata, output logic [PW-1:0] rdata,
                              output logic err);
        int waits;
        waits = 0;
        rdata = '0;
        err   = 1'b0;
        if (timeouts != 0)
            return;
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > APB_MAX) begin
                $display("APB access to 0x%h never completed, pready stayed low", addr);
                timeouts++;
                break;
            end
            @(negedge clk);
        end
        check_err("pready", pready, 1'b1);
        rdata = prdata;                         // Sampled mid-cycle where it is stable
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [AW-1:0] addr, input logic [PW-1:0] data,
                             output logic err);
        logic [PW-1:0] unused_rd;
        apb_access(addr, 1'b1, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [AW-1:0] addr, output logic [PW-1:0] data,
                            output logic err);
        apb_access(addr, 1'b0, '0, data, err);
    endtask

    task automatic wait_idle();
        logic [PW-1:0] st;
        logic          err;
        int            polls;
        polls = 0;
        while (timeouts == 0) begin
            apb_read(spi_reg_pkg::reg_status, st, err);
            if (!st[spi_reg_pkg::STAT_BUSY_BIT])
                break;
            polls++;
            if (polls > POLL_MAX) begin
                $display("Transfer never finished, status busy stayed set");
                timeouts++;
            end
        end
    endtask

    // Control write, transmit write, poll, read back
    task automatic run_transfer(input row_t r, input logic poke_busy);
        logic [PW-1:0] ctrl;
        logic [PW-1:0] rd;
        logic          err;
        logic [DW-1:0] exp_rx;
        exp_rx = (r.bank == MASKED_BANK) ? {DW{1'b1}} : r.reply;   // Unwired MISO
        reply[r.bank] = r.reply;
        mon_bank = r.bank;
        mon_cs   = r.cs;
        le_seen  = 1'b0;
        ctrl = '0;
        ctrl[spi_reg_pkg::CTRL_BANK_LSB +: spi_map_pkg::BANK_W] = r.bank;
        ctrl[spi_reg_pkg::CTRL_CS_LSB +: spi_reg_pkg::CS_IDX_W] = r.cs;
        apb_write(spi_reg_pkg::reg_ctrl, ctrl, err);
        check_err("pslverr", err, 1'b0);
        apb_write(spi_reg_pkg::reg_tx, PW'(r.tx), err);
        check_err("pslverr", err, 1'b0);
        if (poke_busy) begin
            apb_write(spi_reg_pkg::reg_tx, PW'(~r.tx), err);
            check_err("pslverr", err, 1'b1);
        end
        wait_idle();
        if (timeouts != 0)
            return;
        apb_read(spi_reg_pkg::reg_rx, rd, err);
        check_byte("rx_data", rd[DW-1:0], exp_rx);
        check_byte($sformatf("slave_rx[%0d]", r.bank), slv_rx[r.bank], r.tx);
        check_byte($sformatf("slave_bits[%0d]", r.bank), DW'(slv_bits[r.bank]), DW'(8));
        if (poke_busy) begin
            apb_read(spi_reg_pkg::reg_tx, rd, err);
            check_byte("tx_data", rd[DW-1:0], r.tx);
        end
        checks++;
        if (!le_seen) begin
            errors++;
            $display("Chip select %0d of bank %0d never went low", r.cs, r.bank);
        end
    endtask

    // Pin monitor where only the addressed LE of the active bank may drop
    always @(negedge clk) begin
        if (mon_on) begin
            for (int b = 0; b < NB; b++) begin
                if (b == int'(mon_bank)) begin
                    if (bank_le[b] !== {LEW{1'b1}}) begin
                        le_seen = 1'b1;
                        check_pins($sformatf("bank_le[%0d]", b), bank_le[b],
                                   le_pattern(mon_cs));
                    end
                end else begin
                    check_pins($sformatf("bank_le[%0d]", b), bank_le[b], {LEW{1'b1}});
                end
            end
            check_pins("bank_sclk", LEW'(bank_sclk | (NB'(1) << mon_bank)), LEW'({NB{1'b1}}));
            check_pins("bank_mosi", LEW'(bank_mosi | (NB'(1) << mon_bank)), LEW'({NB{1'b1}}));
        end
    end

    initial begin
        logic [PW-1:0] rd;
        logic          err;
        seed     = 32'h3e59a98b;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        mon_on   = 1'b0;
        le_seen  = 1'b0;
        mon_bank = spi_map_pkg::bank_pa;
        mon_cs   = '0;
        reply    = '1;
        arst_n   = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;

        // Bank, chip-select index, transmit byte, slave reply
        rows[0] = '{spi_map_pkg::bank_pa,      3'd0, rand_byte(), rand_byte()};
        rows[1] = '{spi_map_pkg::bank_tx_low,  3'd3, rand_byte(), rand_byte()};
        // Zero reply on the masked bank so any leak of its MISO shows
        rows[2] = '{spi_map_pkg::bank_tx_high, 3'd7, rand_byte(), 8'h00};
        rows[3] = '{spi_map_pkg::bank_orx,     3'd5, rand_byte(), rand_byte()};
        rows[4] = '{spi_map_pkg::bank_pa,      3'd6, rand_byte(), rand_byte()};
        rows[5] = '{spi_map_pkg::bank_tx_high, 3'd1, rand_byte(), rand_byte()};
        rows[6] = '{spi_map_pkg::bank_tx_low,  3'd2, rand_byte(), rand_byte()};

        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Everything parked high out of reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        for (int b = 0; b < NB; b++) begin
            check_pins($sformatf("bank_le[%0d]", b), bank_le[b], {LEW{1'b1}});
        end
        check_pins("bank_sclk", LEW'(bank_sclk), LEW'({NB{1'b1}}));
        check_pins("bank_mosi", LEW'(bank_mosi), LEW'({NB{1'b1}}));
        apb_read(spi_reg_pkg::reg_status, rd, err);
        check_byte("status", rd[DW-1:0], 8'h00);
        check_err("pslverr", err, 1'b0);

        mon_on = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            if (timeouts != 0)
                break;
            run_transfer(rows[i], i == POKE_ROW);
        end

        // Holes in the register map
        apb_write(4'h2, 32'hffff_ffff, err);
        check_err("pslverr", err, 1'b1);
        apb_read(4'h7, rd, err);
        check_err("pslverr", err, 1'b1);
        mon_on = 1'b0;

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
spi_map_pkg.sv
spi_reg_pkg.sv
spi_bus_if.sv
spi_apb_regs.sv
spi_shift_engine.sv
spi_bank_router.sv
spi_bank_port.sv
spi_map_top.sv
tb_spi_slave.sv
tb_spi_map.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_spi_map
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
